// ==== snake_core.f ====
hw/snake_pkg.sv
hw/direction_decoder.sv
hw/snake_mover.sv
hw/point_generator.sv
hw/game_state.sv
hw/snake_core.sv
testbench/snake_checker.sv
testbench/snake_core_tb.sv

// ==== Bender.yml ====
package:
  name: snake_core

sources:
  - hw/snake_pkg.sv
  - hw/direction_decoder.sv
  - hw/snake_mover.sv
  - hw/point_generator.sv
  - hw/game_state.sv
  - hw/snake_core.sv
  - target: test
    files:
      - testbench/snake_checker.sv
      - testbench/snake_core_tb.sv

// ==== testbench/snake_cases.txt ====
# op operand score1 score2 mode, press operand is {btn2,btn1}, step and wait take counts
# score ff is not checked, mode 0 is menu, 1 game, 2 over
wait  08 00 00 0
start 00 00 00 1
step  02 ff ff 1
press 22 ff ff 1
step  01 ff ff 1
press 84 ff ff 1
step  03 ff ff 1
press 48 ff ff 1
step  01 ff ff 1
press 55 ff ff 1
step  03 ff ff 1
step  01 ff ff 2
step  02 ff ff 2
start 00 ff ff 0
wait  04 ff ff 0
start 00 00 00 1
chase 01 01 00 1
wait  04 01 00 1

// ==== testbench/snake_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_core_tb import snake_pkg::*; ;

    logic               clk_75, colision, start, step, seed_rdy, check_req;
    logic [3:0]         btn1, btn2;
    logic [COORD_W-1:0] seed_x_in, seed_y_in, seed_x_out, seed_y_out;
    logic [COORD_W-1:0] head1_x, head1_y, head2_x, head2_y, point_x, point_y;
    logic [SCORE_W-1:0] score1, score2, exp_score1, exp_score2;
    logic [1:0]         exp_mode;
    game_mode           mode;
    int                 checker_errors, run_errors, cycles, cycle_limit, case_count, i;
    int                 case_op [0:63];
    logic [7:0]         case_arg [0:63];
    logic [7:0]         case_s1 [0:63];
    logic [7:0]         case_s2 [0:63];
    logic [1:0]         case_mode [0:63];

    snake_core #(.MAP_WIDTH(DEF_MAP_WIDTH), .MAP_HEIGHT(DEF_MAP_HEIGHT)) snake_core_inst (
        .clk_75(clk_75), .colision(colision), .start(start), .step(step),
        .btn1(btn1), .btn2(btn2), .seed_x_in(seed_x_in), .seed_y_in(seed_y_in),
        .mode(mode), .seed_x_out(seed_x_out), .seed_y_out(seed_y_out), .seed_rdy(seed_rdy),
        .head1_x(head1_x), .head1_y(head1_y), .head2_x(head2_x), .head2_y(head2_y),
        .point_x(point_x), .point_y(point_y), .score1(score1), .score2(score2)
    );

    snake_checker checker_inst (
        .clk_75(clk_75), .colision(colision), .start(start), .step(step),
        .btn1(btn1), .btn2(btn2), .seed_x_in(seed_x_in), .seed_y_in(seed_y_in),
        .mode(mode), .seed_x_out(seed_x_out), .seed_y_out(seed_y_out), .seed_rdy(seed_rdy),
        .head1_x(head1_x), .head1_y(head1_y), .head2_x(head2_x), .head2_y(head2_y),
        .point_x(point_x), .point_y(point_y), .score1(score1), .score2(score2),
        .check_req(check_req), .exp_score1(exp_score1), .exp_score2(exp_score2),
        .exp_mode(exp_mode), .error_count(checker_errors)
    );

    always #50 clk_75 = ~clk_75;

    always @(posedge clk_75) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk_75);
        #5;
    endtask

    function automatic logic [3:0] strobe(logic [1:0] dir);
        return 4'b0001 << dir;
    endfunction

    // player 2 circles a 2x2 square that the chasing player never enters.
    function automatic logic [1:0] escort_dir(int k, logic left_square);
        if (left_square) begin
            case (k % 4)
                0: return UP;
                1: return LEFT;
                2: return DOWN;
                default: return RIGHT;
            endcase
        end
        if (k == 0) return RIGHT;
        case ((k - 1) % 4)
            0: return RIGHT;
            1: return DOWN;
            2: return LEFT;
            default: return UP;
        endcase
    endfunction

    task automatic read_cases();
        int             fd;
        int             n;
        logic [127:0]   word;
        logic [1599:0]  rest;
        fd = $fopen("testbench/snake_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            run_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", word);
            if (n != 1) break;
            if (word == "#") begin
                n = $fgets(rest, fd);
            end else begin
                n = $fscanf(fd, "%h %h %h %h", case_arg[case_count], case_s1[case_count],
                            case_s2[case_count], case_mode[case_count]);
                case (word)
                    "wait":  case_op[case_count] = 0;
                    "start": case_op[case_count] = 1;
                    "press": case_op[case_count] = 2;
                    "step":  case_op[case_count] = 3;
                    "chase": case_op[case_count] = 4;
                    default: begin
                        $display("unknown operation in case file line %0d", case_count);
                        run_errors++;
                    end
                endcase
                case (case_op[case_count])
                    0: cycle_limit += case_arg[case_count] + 1;
                    1: cycle_limit += 8;
                    2: cycle_limit += 3;
                    3: cycle_limit += case_arg[case_count] * 4 + 1;
                    default: cycle_limit += 200;
                endcase
                case_count++;
            end
        end
        $fclose(fd);
        cycle_limit = cycle_limit * 4 + 200 + 16;
    endtask

    // steers player 1 onto the point; it expects a fresh game with both heads at home.
    task automatic chase_point();
        logic [1:0] route[$];
        logic [4:0] hx, hy, px, py;
        logic       left_square;
        int         k;
        hx = head1_x;
        hy = head1_y;
        px = point_x;
        py = point_y;
        left_square = (px >= 24) && (px <= 25) && (py >= 12) && (py <= 13);
        if (hx == px && hy == py) begin
            route = '{UP, RIGHT, DOWN, LEFT};
        end else if (py >= 12 && py <= 13 && px >= 24) begin
            repeat (hy - 9) route.push_back(UP);
            repeat (px - hx) route.push_back(RIGHT);
            repeat (py - 9) route.push_back(DOWN);
        end else begin
            if (py > hy) begin
                route.push_back(RIGHT);
                hx = hx + 5'd1;
                repeat (py - hy) route.push_back(DOWN);
            end else begin
                repeat (hy - py) route.push_back(UP);
            end
            if (px > hx) repeat (px - hx) route.push_back(RIGHT);
            else repeat (hx - px) route.push_back(LEFT);
        end
        for (k = 0; k < route.size(); k++) begin
            btn1 = strobe(route[k]);
            btn2 = strobe(escort_dir(k, left_square));
            next_cycle();
            btn1 = 4'b0000;
            btn2 = 4'b0000;
            step = 1'b1;
            next_cycle();
            step = 1'b0;
            repeat (2) next_cycle();
        end
    endtask

    task automatic run_case(int idx);
        case (case_op[idx])
            0: repeat (case_arg[idx]) next_cycle();
            1: begin
                start = 1'b1;
                next_cycle();
                start = 1'b0;
                repeat (5) next_cycle();
            end
            2: begin
                btn1 = case_arg[idx][3:0];
                btn2 = case_arg[idx][7:4];
                next_cycle();
                btn1 = 4'b0000;
                btn2 = 4'b0000;
                next_cycle();
            end
            3: repeat (case_arg[idx]) begin
                step = 1'b1;
                next_cycle();
                step = 1'b0;
                repeat (3) next_cycle();
            end
            4: chase_point();
            default: ;
        endcase
        exp_score1 = case_s1[idx];
        exp_score2 = case_s2[idx];
        exp_mode = case_mode[idx];
        check_req = 1'b1;
        next_cycle();
        check_req = 1'b0;
    endtask

    initial begin
        clk_75 = 1'b0;
        colision = 1'b1;
        {start, step, check_req} = 3'b000;
        {btn1, btn2} = 8'h00;
        {exp_score1, exp_score2, exp_mode} = '0;
        cycles = 0;
        cycle_limit = 0;
        run_errors = 0;
        case_count = 0;
        seed_x_in = 5'($urandom(60) % 32);
        seed_y_in = 5'($urandom % 32);
        read_cases();
        if (case_count == 0) begin
            $display("the case file holds no cases");
            run_errors++;
        end
        repeat (16) @(posedge clk_75);
        #5 colision = 1'b0;
        for (i = 0; i < case_count; i++) run_case(i);
        repeat (4) next_cycle();
        $display("errors: %0d from checks, %0d from the run", checker_errors, run_errors);
        if (checker_errors == 0 && run_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/snake_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_checker import snake_pkg::*; (
    input  logic               clk_75,
    input  logic               colision,
    input  logic               start,
    input  logic               step,
    input  logic [3:0]         btn1,
    input  logic [3:0]         btn2,
    input  logic [COORD_W-1:0] seed_x_in,
    input  logic [COORD_W-1:0] seed_y_in,
    input  game_mode           mode,
    input  logic [COORD_W-1:0] seed_x_out,
    input  logic [COORD_W-1:0] seed_y_out,
    input  logic               seed_rdy,
    input  logic [COORD_W-1:0] head1_x,
    input  logic [COORD_W-1:0] head1_y,
    input  logic [COORD_W-1:0] head2_x,
    input  logic [COORD_W-1:0] head2_y,
    input  logic [COORD_W-1:0] point_x,
    input  logic [COORD_W-1:0] point_y,
    input  logic [SCORE_W-1:0] score1,
    input  logic [SCORE_W-1:0] score2,
    input  logic               check_req,
    input  logic [SCORE_W-1:0] exp_score1,
    input  logic [SCORE_W-1:0] exp_score2,
    input  logic [1:0]         exp_mode,
    output int                 error_count
);

    logic [1:0] m_mode, m_prev_mode, m_dir1, m_dir2;
    logic [4:0] m_x1, m_y1, m_x2, m_y2, m_px, m_py, m_sx, m_sy;
    logic [7:0] m_s1, m_s2;
    logic       m_restart, m_ate1, m_ate2, m_wall1, m_wall2, m_seed_rdy, m_step_d;
    logic       seed_prev;

    // bit 0 up, 1 down, 2 left, 3 right; a reverse heading differs only in bit 0.
    function automatic logic [1:0] steer(logic [1:0] dir, logic [3:0] btn);
        logic [1:0] req;
        case (btn)
            4'b0001: req = 2'd0;
            4'b0010: req = 2'd1;
            4'b0100: req = 2'd2;
            4'b1000: req = 2'd3;
            default: return dir;
        endcase
        return (req == (dir ^ 2'd1)) ? dir : req;
    endfunction

    function automatic logic [9:0] moved(logic [4:0] x, logic [4:0] y, logic [1:0] dir);
        case (dir)
            2'd0: y = y - 5'd1;
            2'd1: y = y + 5'd1;
            2'd2: x = x - 5'd1;
            default: x = x + 5'd1;
        endcase
        return {x, y};
    endfunction

    function automatic logic on_border(logic [9:0] xy);
        return (xy[9:5] == 0) || (xy[9:5] == DEF_MAP_WIDTH - 1) ||
               (xy[4:0] == 0) || (xy[4:0] == DEF_MAP_HEIGHT - 1);
    endfunction

    function automatic logic [4:0] fold(int value, int span);
        return 5'((value % span) + 1);
    endfunction

    function automatic logic [4:0] scramble(logic [4:0] v);
        return {v[3:0], v[4]} ^ {3'b000, v[4], 1'b0};
    endfunction

    task automatic compare(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch %s: got %h expected %h at %0t", name, got, want, $time);
            error_count++;
        end
    endtask

    initial error_count = 0;

    always @(posedge clk_75 or posedge colision) begin : model
        logic [9:0] next1;
        logic [9:0] next2;
        logic       adv;
        logic       has_point;
        logic       clash;
        if (colision) begin
            m_mode <= MENU;
            m_prev_mode <= MENU;
            m_dir1 <= 2'd0;
            m_dir2 <= 2'd0;
            {m_x1, m_y1, m_x2, m_y2} <= {5'd8, 5'd12, 5'd23, 5'd12};
            {m_px, m_py, m_sx, m_sy} <= {5'd0, 5'd0, 5'd1, 5'd22};
            {m_s1, m_s2} <= '0;
            {m_restart, m_ate1, m_ate2, m_wall1, m_wall2, m_seed_rdy, m_step_d} <= '0;
        end else begin
            adv = step && (m_mode == GAME) && !m_restart;
            next1 = moved(m_x1, m_y1, m_dir1);
            next2 = moved(m_x2, m_y2, m_dir2);
            has_point = (m_px != 0) || (m_py != 0);
            clash = m_step_d && (m_x1 == m_x2) && (m_y1 == m_y2);
            m_dir1 <= m_restart ? 2'd0 : steer(m_dir1, btn1);
            m_dir2 <= m_restart ? 2'd0 : steer(m_dir2, btn2);
            if (m_restart) begin
                {m_x1, m_y1, m_x2, m_y2} <= {5'd8, 5'd12, 5'd23, 5'd12};
            end else if (adv) begin
                {m_x1, m_y1, m_x2, m_y2} <= {next1, next2};
            end
            m_ate1 <= adv && has_point && (next1 == {m_px, m_py});
            m_ate2 <= adv && has_point && (next2 == {m_px, m_py});
            m_wall1 <= adv && on_border(next1);
            m_wall2 <= adv && on_border(next2);
            if (m_mode == MENU) begin
                m_sx <= 5'((m_sx + 1) % 31);
                m_sy <= 5'((m_sy + 1) % 23);
            end
            m_prev_mode <= m_mode;
            m_seed_rdy <= (m_mode == GAME) && (m_prev_mode == MENU);
            if ((m_mode == GAME) && (m_prev_mode == MENU)) begin
                m_px <= fold(m_sx + seed_x_in, DEF_MAP_WIDTH - 2);
                m_py <= fold(m_sy + seed_y_in, DEF_MAP_HEIGHT - 2);
            end else if (m_ate1 || m_ate2) begin
                m_px <= fold(scramble(m_px), DEF_MAP_WIDTH - 2);
                m_py <= fold(scramble(m_py), DEF_MAP_HEIGHT - 2);
            end
            m_step_d <= step;
            m_restart <= (m_mode == MENU) && start;
            if ((m_mode == MENU) && start) begin
                m_mode <= GAME;
                {m_s1, m_s2} <= '0;
            end else begin
                if ((m_mode == GAME) && (m_wall1 || m_wall2 || clash)) m_mode <= OVER;
                if ((m_mode == OVER) && start) m_mode <= MENU;
                if (m_ate1 && m_s1 != 8'hff) m_s1 <= m_s1 + 8'd1;
                if (m_ate2 && m_s2 != 8'hff) m_s2 <= m_s2 + 8'd1;
            end
        end
    end

    always @(negedge clk_75) begin
        if (!colision) begin
            compare("mode", mode, m_mode);
            compare("seed_x_out", seed_x_out, m_sx);
            compare("seed_y_out", seed_y_out, m_sy);
            compare("seed_rdy", seed_rdy, m_seed_rdy);
            compare("head1_x", head1_x, m_x1);
            compare("head1_y", head1_y, m_y1);
            compare("head2_x", head2_x, m_x2);
            compare("head2_y", head2_y, m_y2);
            compare("point_x", point_x, m_px);
            compare("point_y", point_y, m_py);
            compare("score1", score1, m_s1);
            compare("score2", score2, m_s2);
            if (seed_rdy && seed_prev) begin
                $display("seed_rdy stayed high for more than one cycle at %0t", $time);
                error_count++;
            end
            // the first point must follow from the seeds shown during the pulse.
            if (seed_rdy) begin
                compare("point_x", point_x, fold(seed_x_out + seed_x_in, DEF_MAP_WIDTH - 2));
                compare("point_y", point_y, fold(seed_y_out + seed_y_in, DEF_MAP_HEIGHT - 2));
            end
            if (check_req) begin
                compare("mode", mode, exp_mode);
                if (exp_score1 != 8'hff) compare("score1", score1, exp_score1);
                if (exp_score2 != 8'hff) compare("score2", score2, exp_score2);
            end
        end
        seed_prev = seed_rdy;
    end

endmodule

`default_nettype wire

// ==== hw/snake_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_core import snake_pkg::*; #(
    parameter int MAP_WIDTH  = DEF_MAP_WIDTH,
    parameter int MAP_HEIGHT = DEF_MAP_HEIGHT
) (
    input  logic               clk_75,
    input  logic               colision,
    input  logic               start,
    input  logic               step,
    input  logic [3:0]         btn1,
    input  logic [3:0]         btn2,
    input  logic [COORD_W-1:0] seed_x_in,
    input  logic [COORD_W-1:0] seed_y_in,
    output game_mode           mode,
    output logic [COORD_W-1:0] seed_x_out,
    output logic [COORD_W-1:0] seed_y_out,
    output logic               seed_rdy,
    output logic [COORD_W-1:0] head1_x,
    output logic [COORD_W-1:0] head1_y,
    output logic [COORD_W-1:0] head2_x,
    output logic [COORD_W-1:0] head2_y,
    output logic [COORD_W-1:0] point_x,
    output logic [COORD_W-1:0] point_y,
    output logic [SCORE_W-1:0] score1,
    output logic [SCORE_W-1:0] score2
);

    direction heading1;
    direction heading2;
    logic     restart;
    logic     ate1;
    logic     ate2;
    logic     wall_hit1;
    logic     wall_hit2;

    direction_decoder decoder1_inst (
        .clk_75   (clk_75),
        .colision (colision),
        .btn      (btn1),
        .restart  (restart),
        .heading  (heading1)
    );

    direction_decoder decoder2_inst (
        .clk_75   (clk_75),
        .colision (colision),
        .btn      (btn2),
        .restart  (restart),
        .heading  (heading2)
    );

    // player 1 starts on the left half of the board, player 2 on the right.
    snake_mover #(
        .MAP_WIDTH  (MAP_WIDTH),
        .MAP_HEIGHT (MAP_HEIGHT),
        .START_X    (8),
        .START_Y    (12)
    ) mover1_inst (
        .clk_75   (clk_75),
        .colision (colision),
        .mode     (mode),
        .restart  (restart),
        .step     (step),
        .heading  (heading1),
        .point_x  (point_x),
        .point_y  (point_y),
        .head_x   (head1_x),
        .head_y   (head1_y),
        .ate      (ate1),
        .wall_hit (wall_hit1)
    );

    snake_mover #(
        .MAP_WIDTH  (MAP_WIDTH),
        .MAP_HEIGHT (MAP_HEIGHT),
        .START_X    (23),
        .START_Y    (12)
    ) mover2_inst (
        .clk_75   (clk_75),
        .colision (colision),
        .mode     (mode),
        .restart  (restart),
        .step     (step),
        .heading  (heading2),
        .point_x  (point_x),
        .point_y  (point_y),
        .head_x   (head2_x),
        .head_y   (head2_y),
        .ate      (ate2),
        .wall_hit (wall_hit2)
    );

    point_generator #(
        .MAP_WIDTH  (MAP_WIDTH),
        .MAP_HEIGHT (MAP_HEIGHT)
    ) point_generator_inst (
        .clk_75     (clk_75),
        .colision   (colision),
        .mode       (mode),
        .seed_x_in  (seed_x_in),
        .seed_y_in  (seed_y_in),
        .ate1       (ate1),
        .ate2       (ate2),
        .seed_x_out (seed_x_out),
        .seed_y_out (seed_y_out),
        .seed_rdy   (seed_rdy),
        .point_x    (point_x),
        .point_y    (point_y)
    );

    game_state game_state_inst (
        .clk_75    (clk_75),
        .colision  (colision),
        .start     (start),
        .step      (step),
        .ate1      (ate1),
        .ate2      (ate2),
        .wall_hit1 (wall_hit1),
        .wall_hit2 (wall_hit2),
        .head1_x   (head1_x),
        .head1_y   (head1_y),
        .head2_x   (head2_x),
        .head2_y   (head2_y),
        .mode      (mode),
        .restart   (restart),
        .score1    (score1),
        .score2    (score2)
    );

endmodule

`default_nettype wire

// ==== hw/game_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_state import snake_pkg::*; (
    input  logic               clk_75,
    input  logic               colision,
    input  logic               start,
    input  logic               step,
    input  logic               ate1,
    input  logic               ate2,
    input  logic               wall_hit1,
    input  logic               wall_hit2,
    input  logic [COORD_W-1:0] head1_x,
    input  logic [COORD_W-1:0] head1_y,
    input  logic [COORD_W-1:0] head2_x,
    input  logic [COORD_W-1:0] head2_y,
    output game_mode           mode,
    output logic               restart,
    output logic [SCORE_W-1:0] score1,
    output logic [SCORE_W-1:0] score2
);

    logic step_d;
    logic head_clash;
    logic game_start;

    function automatic logic [SCORE_W-1:0] bump(logic [SCORE_W-1:0] score);
        return (&score) ? score : score + 1'b1;
    endfunction

    // heads carry their new value in the cycle after step.
    assign head_clash = step_d && (head1_x == head2_x) && (head1_y == head2_y);
    assign game_start = (mode == MENU) && start;

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            step_d <= 1'b0;
        end else begin
            step_d <= step;
        end
    end

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            mode    <= MENU;
            restart <= 1'b0;
        end else begin
            restart <= game_start;
            case (mode)
                MENU: if (start) mode <= GAME;
                GAME: if (wall_hit1 || wall_hit2 || head_clash) mode <= OVER;
                default: if (start) mode <= MENU;
            endcase
        end
    end

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            score1 <= '0;
            score2 <= '0;
        end else if (game_start) begin
            score1 <= '0;
            score2 <= '0;
        end else begin
            if (ate1) score1 <= bump(score1);
            if (ate2) score2 <= bump(score2);
        end
    end

endmodule

`default_nettype wire

// ==== hw/point_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

module point_generator import snake_pkg::*; #(
    parameter int MAP_WIDTH  = DEF_MAP_WIDTH,
    parameter int MAP_HEIGHT = DEF_MAP_HEIGHT
) (
    input  logic               clk_75,
    input  logic               colision,
    input  game_mode           mode,
    input  logic [COORD_W-1:0] seed_x_in,
    input  logic [COORD_W-1:0] seed_y_in,
    input  logic               ate1,
    input  logic               ate2,
    output logic [COORD_W-1:0] seed_x_out,
    output logic [COORD_W-1:0] seed_y_out,
    output logic               seed_rdy,
    output logic [COORD_W-1:0] point_x,
    output logic [COORD_W-1:0] point_y
);

    // the playable span excludes the two border tiles.
    localparam int SPAN_X = MAP_WIDTH - 2;
    localparam int SPAN_Y = MAP_HEIGHT - 2;

    localparam logic [COORD_W-1:0] SEED_X_LAST = COORD_W'(30);
    localparam logic [COORD_W-1:0] SEED_Y_LAST = COORD_W'(22);

    logic [COORD_W-1:0] seed_x;
    logic [COORD_W-1:0] seed_y;
    game_mode           mode_prev;
    logic               game_entry;
    logic               eaten;

    // folds a value into the playable range 1 .. span.
    function automatic logic [COORD_W-1:0] place(logic [COORD_W:0] value, int span);
        logic [COORD_W:0] folded;
        folded = value % (COORD_W + 1)'(span);
        return COORD_W'(folded) + 1'b1;
    endfunction

    assign game_entry = (mode == GAME) && (mode_prev == MENU);
    assign eaten      = ate1 || ate2;

    assign seed_x_out = seed_x;
    assign seed_y_out = seed_y;

    // the seeds only run in the menu, so their value is frozen once the game starts.
    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            seed_x <= COORD_W'(1);
            seed_y <= SEED_Y_LAST;
        end else if (mode == MENU) begin
            seed_x <= (seed_x == SEED_X_LAST) ? '0 : seed_x + 1'b1;
            seed_y <= (seed_y == SEED_Y_LAST) ? '0 : seed_y + 1'b1;
        end
    end

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            mode_prev <= MENU;
            seed_rdy  <= 1'b0;
        end else begin
            mode_prev <= mode;
            seed_rdy  <= game_entry;
        end
    end

    // a simultaneous eat by both players still costs only one LFSR step.
    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            point_x <= '0;
            point_y <= '0;
        end else if (game_entry) begin
            point_x <= place({1'b0, seed_x} + {1'b0, seed_x_in}, SPAN_X);
            point_y <= place({1'b0, seed_y} + {1'b0, seed_y_in}, SPAN_Y);
        end else if (eaten) begin
            point_x <= place({1'b0, lfsr_next(point_x)}, SPAN_X);
            point_y <= place({1'b0, lfsr_next(point_y)}, SPAN_Y);
        end
    end

endmodule

`default_nettype wire

// ==== hw/snake_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

module snake_mover import snake_pkg::*; #(
    parameter int MAP_WIDTH  = DEF_MAP_WIDTH,
    parameter int MAP_HEIGHT = DEF_MAP_HEIGHT,
    parameter int START_X    = 8,
    parameter int START_Y    = 12
) (
    input  logic               clk_75,
    input  logic               colision,
    input  game_mode           mode,
    input  logic               restart,
    input  logic               step,
    input  direction           heading,
    input  logic [COORD_W-1:0] point_x,
    input  logic [COORD_W-1:0] point_y,
    output logic [COORD_W-1:0] head_x,
    output logic [COORD_W-1:0] head_y,
    output logic               ate,
    output logic               wall_hit
);

    localparam logic [COORD_W-1:0] HOME_X = COORD_W'(START_X);
    localparam logic [COORD_W-1:0] HOME_Y = COORD_W'(START_Y);
    localparam logic [COORD_W-1:0] LAST_X = COORD_W'(MAP_WIDTH - 1);
    localparam logic [COORD_W-1:0] LAST_Y = COORD_W'(MAP_HEIGHT - 1);

    logic [COORD_W-1:0] next_x;
    logic [COORD_W-1:0] next_y;
    logic               advance;
    logic               point_valid;
    logic               next_on_point;
    logic               next_on_wall;

    always_comb begin
        next_x = head_x;
        next_y = head_y;
        case (heading)
            UP:      next_y = head_y - 1'b1;
            DOWN:    next_y = head_y + 1'b1;
            LEFT:    next_x = head_x - 1'b1;
            default: next_x = head_x + 1'b1;
        endcase
    end

    assign advance = step && (mode == GAME) && !restart;

    // a point at 0,0 means none has been placed yet.
    assign point_valid   = (point_x != '0) || (point_y != '0);
    assign next_on_point = point_valid && (next_x == point_x) && (next_y == point_y);

    assign next_on_wall = (next_x == '0) || (next_x == LAST_X) ||
                          (next_y == '0) || (next_y == LAST_Y);

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            head_x <= HOME_X;
            head_y <= HOME_Y;
        end else if (restart) begin
            head_x <= HOME_X;
            head_y <= HOME_Y;
        end else if (advance) begin
            head_x <= next_x;
            head_y <= next_y;
        end
    end

    // both flags line up with the cycle in which the new head shows.
    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            ate      <= 1'b0;
            wall_hit <= 1'b0;
        end else begin
            ate      <= advance && next_on_point;
            wall_hit <= advance && next_on_wall;
        end
    end

endmodule

`default_nettype wire

// ==== hw/direction_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// btn bit 0 is up, bit 1 down, bit 2 left and bit 3 right.
module direction_decoder import snake_pkg::*; (
    input  logic       clk_75,
    input  logic       colision,
    input  logic [3:0] btn,
    input  logic       restart,
    output direction   heading
);

    direction requested;
    logic     one_hot;
    logic     accept;

    function automatic direction opposite(direction dir);
        case (dir)
            UP:      return DOWN;
            DOWN:    return UP;
            LEFT:    return RIGHT;
            default: return LEFT;
        endcase
    endfunction

    always_comb begin
        one_hot = 1'b1;
        case (btn)
            4'b0001: requested = UP;
            4'b0010: requested = DOWN;
            4'b0100: requested = LEFT;
            4'b1000: requested = RIGHT;
            default: begin
                requested = heading;
                one_hot   = 1'b0;
            end
        endcase
    end

    // a snake may not turn straight back into itself.
    assign accept = one_hot && (requested != opposite(heading));

    always_ff @(posedge clk_75 or posedge colision) begin
        if (colision) begin
            heading <= UP;
        end else if (restart) begin
            heading <= UP;
        end else if (accept) begin
            heading <= requested;
        end
    end

endmodule

`default_nettype wire

// ==== hw/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

    // the core only ever sits in one of these three modes.
    typedef enum logic [1:0] {
        MENU = 2'd0,
        GAME = 2'd1,
        OVER = 2'd2
    } game_mode;

    typedef enum logic [1:0] {
        UP    = 2'd0,
        DOWN  = 2'd1,
        LEFT  = 2'd2,
        RIGHT = 2'd3
    } direction;

    localparam int COORD_W = 5;
    localparam int SCORE_W = 8;

    // board size in tiles, border included.
    localparam int DEF_MAP_WIDTH  = 32;
    localparam int DEF_MAP_HEIGHT = 24;

    // one step of the food LFSR on a single coordinate.
    // the top bit wraps into bit 0 and is also folded into bit 1.
    function automatic logic [COORD_W-1:0] lfsr_next(logic [COORD_W-1:0] value);
        logic [COORD_W-1:0] shifted;
        shifted    = {value[COORD_W-2:0], value[COORD_W-1]};
        shifted[1] = shifted[1] ^ value[COORD_W-1];
        return shifted;
    endfunction

endpackage

`default_nettype wire
